// ==== compile.f ====
+incdir+logic
logic/stream_pkg.sv
logic/lane_pkg.sv
logic/reset_sync.sv
logic/lane_distributor.sv
logic/lane_async_fifo.sv
logic/lane_merger.sv
logic/striped_cdc_fifo.sv
testbench/striped_cdc_fifo_assert.sv
testbench/striped_cdc_fifo_tb.sv

// ==== logic/lane_async_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module lane_async_fifo #(
  parameter int ADDR_WIDTH = `STREAM_LANE_ADDR_WIDTH
) (
  input  wire               input_clk,
  input  wire               input_rst_sync3,
  input  stream_pkg::beat_t wr_beat,
  input  wire               wr_valid,
  output logic              wr_ready,
  input  wire               output_clk,
  input  wire               output_rst_sync3,
  output stream_pkg::beat_t rd_beat,
  output logic              rd_valid,
  input  wire               rd_ready
);

  import stream_pkg::*;

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] wr_ptr_next;
  logic [ADDR_WIDTH:0] wr_ptr_gray;
  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] rd_ptr_next;
  logic [ADDR_WIDTH:0] rd_ptr_gray;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync1;
  logic [ADDR_WIDTH:0] wr_ptr_gray_sync2;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync1;
  logic [ADDR_WIDTH:0] rd_ptr_gray_sync2;

  beat_t mem [DEPTH];
  beat_t rd_beat_reg;
  logic  rd_valid_reg;
  logic  full;
  logic  empty;
  logic  write;
  logic  read;

  // full when the top two gray bits differ and the rest match
  assign full  = (wr_ptr_gray ^ rd_ptr_gray_sync2) ==
                 {2'b11, {(ADDR_WIDTH-1){1'b0}}};
  assign empty = rd_ptr_gray == wr_ptr_gray_sync2;

  assign wr_ready = ~full & ~input_rst_sync3;
  assign write    = wr_valid & wr_ready;
  assign read     = (rd_ready | ~rd_valid_reg) & ~empty;  // refill when free

  assign rd_beat  = rd_beat_reg;
  assign rd_valid = rd_valid_reg;

  assign wr_ptr_next = wr_ptr + 1'b1;
  assign rd_ptr_next = rd_ptr + 1'b1;

  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else if (write) begin
      wr_ptr      <= wr_ptr_next;
      wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
    end
  end

  always_ff @(posedge input_clk) begin
    if (write) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_beat;
    end
  end

  // read pointer into the write domain
  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      rd_ptr_gray_sync1 <= '0;
      rd_ptr_gray_sync2 <= '0;
    end else begin
      rd_ptr_gray_sync1 <= rd_ptr_gray;
      rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else if (read) begin
      rd_ptr      <= rd_ptr_next;
      rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
    end
  end

  always_ff @(posedge output_clk) begin
    if (read) begin
      rd_beat_reg <= mem[rd_ptr[ADDR_WIDTH-1:0]];
    end
  end

  // write pointer into the read domain
  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      wr_ptr_gray_sync1 <= '0;
      wr_ptr_gray_sync2 <= '0;
    end else begin
      wr_ptr_gray_sync1 <= wr_ptr_gray;
      wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
    end
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      rd_valid_reg <= 1'b0;
    end else if (rd_ready | ~rd_valid_reg) begin
      rd_valid_reg <= ~empty;
    end
  end

endmodule

`default_nettype wire

// ==== logic/lane_distributor.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_distributor (
  input  wire                 input_clk,
  input  wire                 input_rst_sync3,
  input  stream_pkg::beat_t   in_beat,
  input  wire                 in_valid,
  output logic                in_ready,
  output stream_pkg::beat_t   lane_beat,
  output lane_pkg::lane_vec_t lane_valid,
  input  lane_pkg::lane_vec_t lane_ready
);

  import stream_pkg::*;
  import lane_pkg::*;

  lane_idx_t lane_ptr;  // lane taking the next beat
  logic      in_xfer;

  // every lane sees the same beat, only one gets valid
  assign lane_beat = in_beat;

  always_comb begin
    lane_valid           = '0;
    lane_valid[lane_ptr] = in_valid;
  end

  assign in_ready = lane_ready[lane_ptr] & ~input_rst_sync3;
  assign in_xfer  = in_valid & in_ready;

  // wraps on its own, lane count is a power of two
  always_ff @(posedge input_clk) begin
    if (input_rst_sync3) begin
      lane_ptr <= '0;
    end else if (in_xfer) begin
      lane_ptr <= lane_idx_t'(lane_ptr + 1'b1);
    end
  end

endmodule

`default_nettype wire

// ==== logic/lane_merger.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module lane_merger (
  input  wire                 output_clk,
  input  wire                 output_rst_sync3,
  input  stream_pkg::beat_t   lane_beat [`STREAM_LANES],
  input  lane_pkg::lane_vec_t lane_valid,
  output lane_pkg::lane_vec_t lane_ready,
  output stream_pkg::beat_t   out_beat,
  output logic                out_valid,
  input  wire                 out_ready
);

  import stream_pkg::*;
  import lane_pkg::*;

  lane_idx_t lane_ptr;  // lane holding the next beat in order
  beat_t     sel_beat;
  logic      out_xfer;

  assign sel_beat  = lane_beat[lane_ptr];
  assign out_beat  = sel_beat;
  assign out_valid = lane_valid[lane_ptr];
  assign out_xfer  = out_valid & out_ready;

  // only the current lane sees out_ready
  always_comb begin
    lane_ready           = '0;
    lane_ready[lane_ptr] = out_ready;
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      lane_ptr <= '0;
    end else if (out_xfer) begin
      lane_ptr <= lane_idx_t'(lane_ptr + 1'b1);
    end
  end

endmodule

`default_nettype wire

// ==== logic/lane_pkg.sv ====
`default_nettype none

`include "stream_params.svh"

package lane_pkg;

  // lane number
  typedef logic [$clog2(`STREAM_LANES)-1:0] lane_idx_t;

  // per-lane valid or ready
  typedef logic [`STREAM_LANES-1:0] lane_vec_t;

endpackage

`default_nettype wire

// ==== logic/reset_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_sync (
  input  wire  async_rst,
  input  wire  input_clk,
  input  wire  output_clk,
  output logic input_rst_sync3,
  output logic output_rst_sync3
);

  logic input_rst_sync1;
  logic input_rst_sync2;
  logic output_rst_sync1;
  logic output_rst_sync2;

  // input chain, also held while the output side is still in reset
  always_ff @(posedge input_clk or posedge async_rst) begin
    if (async_rst) begin
      input_rst_sync1 <= 1'b1;
      input_rst_sync2 <= 1'b1;
      input_rst_sync3 <= 1'b1;
    end else begin
      input_rst_sync1 <= 1'b0;
      input_rst_sync2 <= input_rst_sync1 | output_rst_sync1;  // cross-domain hold
      input_rst_sync3 <= input_rst_sync2;
    end
  end

  always_ff @(posedge output_clk or posedge async_rst) begin
    if (async_rst) begin
      output_rst_sync1 <= 1'b1;
      output_rst_sync2 <= 1'b1;
      output_rst_sync3 <= 1'b1;
    end else begin
      output_rst_sync1 <= 1'b0;
      output_rst_sync2 <= output_rst_sync1;
      output_rst_sync3 <= output_rst_sync2;
    end
  end

endmodule

`default_nettype wire

// ==== logic/stream_params.svh ====
`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// tdata bits per beat
`define STREAM_DATA_WIDTH 8

// fifo lanes, power of two
`define STREAM_LANES 4

// address bits of one lane memory
`define STREAM_LANE_ADDR_WIDTH 3

`endif

// ==== logic/stream_pkg.sv ====
`default_nettype none

`include "stream_params.svh"

package stream_pkg;

  // one word of the stream
  typedef struct packed {
    logic [`STREAM_DATA_WIDTH-1:0] data;
    logic                          last;  // end of frame
    logic                          user;  // sideband bit
  } beat_t;

endpackage

`default_nettype wire

// ==== logic/striped_cdc_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module striped_cdc_fifo (
  input  wire               async_rst,
  input  wire               input_clk,
  input  wire               output_clk,
  input  stream_pkg::beat_t in_beat,
  input  wire               in_valid,
  output logic              in_ready,
  output stream_pkg::beat_t out_beat,
  output logic              out_valid,
  input  wire               out_ready
);

  import stream_pkg::*;
  import lane_pkg::*;

  logic      input_rst_sync3;
  logic      output_rst_sync3;

  // input_clk side of the lanes
  beat_t     lane_wr_beat;
  lane_vec_t lane_wr_valid;
  lane_vec_t lane_wr_ready;

  // output_clk side of the lanes
  beat_t     lane_rd_beat [`STREAM_LANES];
  lane_vec_t lane_rd_valid;
  lane_vec_t lane_rd_ready;

  reset_sync reset_sync_inst (
    .async_rst        (async_rst),
    .input_clk        (input_clk),
    .output_clk       (output_clk),
    .input_rst_sync3  (input_rst_sync3),
    .output_rst_sync3 (output_rst_sync3)
  );

  lane_distributor lane_distributor_inst (
    .input_clk       (input_clk),
    .input_rst_sync3 (input_rst_sync3),
    .in_beat         (in_beat),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .lane_beat       (lane_wr_beat),
    .lane_valid      (lane_wr_valid),
    .lane_ready      (lane_wr_ready)
  );

  for (genvar i = 0; i < `STREAM_LANES; i++) begin : g_lane
    lane_async_fifo #(
      .ADDR_WIDTH (`STREAM_LANE_ADDR_WIDTH)
    ) lane_async_fifo_inst (
      .input_clk        (input_clk),
      .input_rst_sync3  (input_rst_sync3),
      .wr_beat          (lane_wr_beat),
      .wr_valid         (lane_wr_valid[i]),
      .wr_ready         (lane_wr_ready[i]),
      .output_clk       (output_clk),
      .output_rst_sync3 (output_rst_sync3),
      .rd_beat          (lane_rd_beat[i]),
      .rd_valid         (lane_rd_valid[i]),
      .rd_ready         (lane_rd_ready[i])
    );
  end

  lane_merger lane_merger_inst (
    .output_clk       (output_clk),
    .output_rst_sync3 (output_rst_sync3),
    .lane_beat        (lane_rd_beat),
    .lane_valid       (lane_rd_valid),
    .lane_ready       (lane_rd_ready),
    .out_beat         (out_beat),
    .out_valid        (out_valid),
    .out_ready        (out_ready)
  );

endmodule

`default_nettype wire

// ==== testbench/striped_cdc_fifo_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module striped_cdc_fifo_assert (
  input wire                    input_clk,
  input wire                    output_clk,
  input wire                    input_rst_sync3,
  input wire                    output_rst_sync3,
  input wire                    in_ready,
  input wire stream_pkg::beat_t out_beat,
  input wire                    out_valid,
  input wire                    out_ready
);

  // a stalled beat stays put until taken
  property out_hold_p;
    @(posedge output_clk) disable iff (output_rst_sync3)
      out_valid && !out_ready |=> out_valid && $stable(out_beat);
  endproperty

  // one edge in reset already clears the output register
  property out_idle_in_reset_p;
    @(posedge output_clk) output_rst_sync3 |=> !out_valid;
  endproperty

  property in_blocked_in_reset_p;
    @(posedge input_clk) input_rst_sync3 |-> !in_ready;
  endproperty

  out_hold_a: assert property (out_hold_p)
    else $error("out_beat or out_valid changed while out_ready was low");

  out_idle_in_reset_a: assert property (out_idle_in_reset_p)
    else $error("out_valid high during output reset");

  in_blocked_in_reset_a: assert property (in_blocked_in_reset_p)
    else $error("in_ready high during input reset");

endmodule

bind striped_cdc_fifo striped_cdc_fifo_assert striped_cdc_fifo_assert_inst (
  .input_clk        (input_clk),
  .output_clk       (output_clk),
  .input_rst_sync3  (input_rst_sync3),
  .output_rst_sync3 (output_rst_sync3),
  .in_ready         (in_ready),
  .out_beat         (out_beat),
  .out_valid        (out_valid),
  .out_ready        (out_ready)
);

`default_nettype wire

// ==== testbench/striped_cdc_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stream_params.svh"

module striped_cdc_fifo_tb;

  import stream_pkg::*;

  localparam int     IN_HALF     = 7;   // 14 ns input_clk
  localparam int     OUT_HALF    = 10;  // 20 ns output_clk
  localparam int     OUT_PERIOD  = 2 * OUT_HALF;
  localparam int     NUM_PHASES  = 5;
  localparam int     BLOCK_LIMIT = 40;  // input cycles of in_ready low that count as full
  localparam int     DRAIN_LIMIT = 200; // output cycles allowed for the final drain
  localparam longint MARGIN_NS   = 20000;

  // each lane holds its memory plus the refilled output register
  localparam int CAPACITY = `STREAM_LANES * (2 ** `STREAM_LANE_ADDR_WIDTH + 1);

  typedef struct packed {
    logic [15:0] beats;
    logic [7:0]  gap_pct;   // chance of an idle input cycle before a beat
    logic [7:0]  duty_pct;  // chance of out_ready per output cycle
    logic        stall;     // out_ready held low until the input blocks
  } phase_t;

  logic  async_rst;
  logic  input_clk  = 1'b0;
  logic  output_clk = 1'b0;
  beat_t in_beat;
  logic  in_valid;
  logic  in_ready;
  beat_t out_beat;
  logic  out_valid;
  logic  out_ready;

  phase_t      phase_tab [NUM_PHASES];
  beat_t       expected_q [$];
  int          errors         = 0;
  int          checks         = 0;
  int          in_count       = 0;
  int          out_count      = 0;
  int          beat_seq       = 0;
  int          phase_accepted = 0;
  int          ready_duty     = 100;
  bit          stall_hold     = 1'b0;
  bit          monitor_on     = 1'b0;
  bit          table_loaded   = 1'b0;

  always #IN_HALF input_clk = ~input_clk;
  always #OUT_HALF output_clk = ~output_clk;

  striped_cdc_fifo striped_cdc_fifo_inst (
    .async_rst  (async_rst),
    .input_clk  (input_clk),
    .output_clk (output_clk),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic load_phases();
    // beats, gap %, duty %, stall
    phase_tab[0] = '{16'd40, 8'd0,  8'd100, 1'b0};  // steady flow
    phase_tab[1] = '{16'd40, 8'd0,  8'd100, 1'b1};  // fill every lane
    phase_tab[2] = '{16'd60, 8'd30, 8'd60,  1'b0};
    phase_tab[3] = '{16'd50, 8'd50, 8'd30,  1'b0};
    phase_tab[4] = '{16'd40, 8'd10, 8'd90,  1'b0};
    table_loaded = 1'b1;
  endtask

  function automatic beat_t make_beat();
    beat_t       b;
    int unsigned r;
    r      = $urandom;
    b.data = r[`STREAM_DATA_WIDTH-1:0];
    r      = $urandom;
    b.user = r[0];
    b.last = (beat_seq % 5 == 4);  // every 5th beat ends a frame
    beat_seq++;
    return b;
  endfunction

  // returns at the falling edge before the posedge that takes the beat
  task automatic send_beat(input beat_t b, input int gap_pct, input bit stall);
    int waited;
    waited = 0;
    while ($urandom_range(99) < gap_pct) begin
      @(negedge input_clk);
      in_valid = 1'b0;
    end
    @(negedge input_clk);
    in_beat  = b;
    in_valid = 1'b1;
    while (in_ready !== 1'b1) begin
      if (stall && stall_hold && waited == BLOCK_LIMIT) begin
        check_value("beats accepted with output stalled", phase_accepted, CAPACITY);
        stall_hold = 1'b0;  // lanes may drain now
      end
      @(negedge input_clk);
      waited++;
    end
    expected_q.push_back(b);
    in_count++;
    phase_accepted++;
  endtask

  task automatic idle_input();
    @(negedge input_clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (expected_q.size() != 0) begin
      @(negedge output_clk);
    end
  endtask

  task automatic run_phase(input phase_t ph);
    wait_drained();
    ready_duty     = ph.duty_pct;
    stall_hold     = ph.stall;
    phase_accepted = 0;
    repeat (2) @(negedge output_clk);  // let out_ready settle
    for (int i = 0; i < ph.beats; i++) begin
      send_beat(make_beat(), ph.gap_pct, ph.stall);
    end
    idle_input();
    if (stall_hold) begin
      // input never blocked during the stall
      check_value("beats accepted with output stalled", phase_accepted, CAPACITY);
      stall_hold = 1'b0;
    end
  endtask

  // drives out_ready and scores each output transfer
  initial begin : output_monitor
    beat_t exp_beat;
    forever begin
      @(negedge output_clk);
      if (stall_hold) begin
        out_ready = 1'b0;
      end else begin
        out_ready = ($urandom_range(99) < ready_duty);
      end
      if (monitor_on) begin
        if (out_valid === 1'b1 && out_ready === 1'b1) begin
          out_count++;  // every transfer seen at the output
        end
        if (expected_q.size() == 0) begin
          check_value("out_valid with no beat pending", out_valid, 1'b0);
        end else if (out_valid === 1'b1 && out_ready === 1'b1) begin
          exp_beat = expected_q.pop_front();
          check_value("tdata", out_beat.data, exp_beat.data);
          check_value("tlast", out_beat.last, exp_beat.last);
          check_value("tuser", out_beat.user, exp_beat.user);
        end
      end
    end
  end

  initial begin : watchdog
    longint limit_ns;
    int     total;
    total = 0;
    wait (table_loaded);
    for (int p = 0; p < NUM_PHASES; p++) begin
      total += phase_tab[p].beats;
    end
    limit_ns = longint'(total) * 4 * OUT_PERIOD + MARGIN_NS;
    #(limit_ns);
    $display("run timed out after %0d ns, %0d beats still expected at the output",
             limit_ns, expected_q.size());
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h28d1_1b5e));
    async_rst = 1'b0;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b0;
    load_phases();
    #1;
    async_rst = 1'b1;
    repeat (3) @(posedge output_clk);
    @(negedge output_clk);
    async_rst  = 1'b0;
    monitor_on = 1'b1;
    repeat (20) @(negedge output_clk);  // nothing sent, output must stay idle
    for (int p = 0; p < NUM_PHASES; p++) begin
      run_phase(phase_tab[p]);
    end
    for (int c = 0; c < DRAIN_LIMIT && expected_q.size() != 0; c++) begin
      @(negedge output_clk);
    end
    repeat (20) @(negedge output_clk);
    check_value("scoreboard entries left", expected_q.size(), 0);
    check_value("beats out against beats in", out_count, in_count);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
